// ==== flist.f ====
logic/i2c_pkg.sv
logic/i2c_sequencer.sv
logic/i2c_phase_gen.sv
logic/i2c_status.sv
logic/i2c_master.sv
verification/i2c_slave_model.sv
verification/tb_i2c_master.sv

// ==== logic/i2c_master.sv ====
`default_nettype none

module i2c_master import i2c_pkg::*; #(
	parameter int STOP_CYCLES = 6
) (
	input  wire        clk_in,
	input  wire        rst_n,
	input  wire        i2c_mode_t mode,
	input  wire        dev_addr_t dev_addr,
	input  wire        byte_t reg_addr,
	input  wire        byte_t wr_data,
	input  wire        count_t byte_count,
	output logic       scl,
	inout  wire        sda,
	output byte_t      rd_data,
	output logic       rd_valid,
	output ack_flags_t ack_status,
	output logic       xfer_done
);

	phase_cmd_t cmd;
	logic       phase_done;
	logic       ack_bit;
	byte_t      rx_byte;
	logic       scl_level;
	logic       sda_drive_low;

	logic       ev_phase_end;
	logic       ev_byte_read;
	logic       ev_xfer_end;
	phase_t     ev_phase;
	logic       ev_ack;

	// open drain, pullup is external
	assign sda = sda_drive_low ? 1'b0 : 1'bz;
	assign scl = scl_level;

	i2c_sequencer seq0 (
		.clk_in       (clk_in),
		.rst_n        (rst_n),
		.mode         (mode),
		.dev_addr     (dev_addr),
		.reg_addr     (reg_addr),
		.wr_data      (wr_data),
		.byte_count   (byte_count),
		.phase_done   (phase_done),
		.ack_bit      (ack_bit),
		.cmd          (cmd),
		.ev_phase_end (ev_phase_end),
		.ev_byte_read (ev_byte_read),
		.ev_xfer_end  (ev_xfer_end),
		.ev_phase     (ev_phase),
		.ev_ack       (ev_ack)
	);

	i2c_phase_gen #(
		.STOP_CYCLES (STOP_CYCLES)
	) phy0 (
		.clk_in        (clk_in),
		.rst_n         (rst_n),
		.cmd           (cmd),
		.sda_in        (sda),
		.scl_level     (scl_level),
		.sda_drive_low (sda_drive_low),
		.phase_done    (phase_done),
		.ack_bit       (ack_bit),
		.rx_byte       (rx_byte)
	);

	i2c_status stat0 (
		.clk_in       (clk_in),
		.rst_n        (rst_n),
		.ev_phase_end (ev_phase_end),
		.ev_byte_read (ev_byte_read),
		.ev_xfer_end  (ev_xfer_end),
		.ev_phase     (ev_phase),
		.ev_ack       (ev_ack),
		.rx_byte      (rx_byte),
		.rd_data      (rd_data),
		.rd_valid     (rd_valid),
		.ack_status   (ack_status),
		.xfer_done    (xfer_done)
	);

endmodule

`default_nettype wire

// ==== logic/i2c_phase_gen.sv ====
`default_nettype none

module i2c_phase_gen import i2c_pkg::*; #(
	parameter int STOP_CYCLES = 6
) (
	input  wire        clk_in,
	input  wire        rst_n,
	input  wire        phase_cmd_t cmd,
	input  wire        sda_in,
	output logic       scl_level,
	output logic       sda_drive_low,
	output logic       phase_done,
	output logic       ack_bit,
	output byte_t      rx_byte
);

	// the byte phase is the longest unless stop is stretched
	localparam int MAX_CYCLES = (STOP_CYCLES > BYTE_CYCLES) ? STOP_CYCLES : BYTE_CYCLES;
	localparam int STEP_W     = $clog2(MAX_CYCLES);

	logic [STEP_W-1:0] step;
	logic [STEP_W-1:0] last_step;
	logic [2:0]        bit_idx;
	logic              scl_rise; // next edge raises scl

	always_comb begin
		case (cmd.phase)
			ph_start:   last_step = STEP_W'(START_CYCLES - 1);
			ph_tx_byte: last_step = STEP_W'(BYTE_CYCLES - 1);
			ph_rx_byte: last_step = STEP_W'(BYTE_CYCLES - 1);
			ph_rx_ack:  last_step = STEP_W'(ACK_CYCLES - 1);
			ph_tx_ack:  last_step = STEP_W'(ACK_CYCLES - 1);
			ph_tx_nack: last_step = STEP_W'(ACK_CYCLES - 1);
			ph_restart: last_step = STEP_W'(RESTART_CYCLES - 1);
			ph_stop:    last_step = STEP_W'(STOP_CYCLES - 1);
			default:    last_step = '0;
		endcase
	end

	assign phase_done = (cmd.phase != ph_idle) && (step == last_step);

	always_ff @(posedge clk_in or negedge rst_n) begin
		if (!rst_n)
			step <= '0;
		else if (phase_done || cmd.phase == ph_idle)
			step <= '0;
		else
			step <= step + 1'b1;
	end

	// msb first, one bit per scl low/high pair
	assign bit_idx  = 3'd7 - step[3:1];
	assign scl_rise = !step[0];

	always_comb begin
		scl_level     = 1'b1;
		sda_drive_low = 1'b0;
		case (cmd.phase)
			ph_start: begin
				sda_drive_low = (step != '0);          // sda falls first
				scl_level     = (step != STEP_W'(2));  // then scl
			end
			ph_tx_byte: begin
				scl_level     = step[0];
				sda_drive_low = !cmd.tx[bit_idx];
			end
			ph_rx_byte, ph_rx_ack, ph_tx_nack: begin
				scl_level = step[0]; // sda left to the slave or released
			end
			ph_tx_ack: begin
				scl_level     = step[0];
				sda_drive_low = 1'b1;
			end
			ph_restart: begin
				// both lines up, then a fresh start
				scl_level     = (step == STEP_W'(1)) || (step == STEP_W'(2));
				sda_drive_low = step[1];
			end
			ph_stop: begin
				scl_level     = (step != '0);
				sda_drive_low = (step < STEP_W'(2)); // released while scl high
			end
			default: begin
				scl_level     = 1'b1;
				sda_drive_low = 1'b0;
			end
		endcase
	end

	always_ff @(posedge clk_in or negedge rst_n) begin
		if (!rst_n)
			ack_bit <= 1'b1;
		else if (cmd.phase == ph_rx_ack && scl_rise)
			ack_bit <= sda_in;
	end

	always_ff @(posedge clk_in) begin
		if (cmd.phase == ph_rx_byte && scl_rise)
			rx_byte <= {rx_byte[6:0], sda_in};
	end

endmodule

`default_nettype wire

// ==== logic/i2c_pkg.sv ====
`default_nettype none

package i2c_pkg;

	typedef logic [6:0] dev_addr_t;
	typedef logic [7:0] byte_t;
	typedef logic [7:0] count_t; // data bytes per transfer, 0 acts as 1

	// register modes, codes kept from the old config byte
	typedef enum logic [2:0] {
		wait_bus     = 3'd0,
		write_single = 3'd1,
		write_burst  = 3'd2,
		read_single  = 3'd4,
		read_burst   = 3'd5
	} i2c_mode_t;

	typedef enum logic [3:0] {
		ph_idle,
		ph_start,
		ph_tx_byte,
		ph_rx_ack,
		ph_restart,
		ph_rx_byte,
		ph_tx_ack,
		ph_tx_nack,
		ph_stop
	} phase_t;

	// clk_in cycles per phase, two per scl bit
	parameter int START_CYCLES   = 3;
	parameter int BYTE_CYCLES    = 16;
	parameter int ACK_CYCLES     = 2;
	parameter int RESTART_CYCLES = 4;

	typedef struct packed {
		phase_t phase;
		byte_t  tx; // only meaningful for ph_tx_byte
	} phase_cmd_t;

	// dev_ack lands on bit 0, same order as the old ack byte
	typedef struct packed {
		logic nack;
		logic master_nack;
		logic master_ack;
		logic rd_dev_ack;
		logic wr_ack;
		logic reg_ack;
		logic dev_ack;
	} ack_flags_t;

endpackage

`default_nettype wire

// ==== logic/i2c_sequencer.sv ====
`default_nettype none

module i2c_sequencer import i2c_pkg::*; (
	input  wire        clk_in,
	input  wire        rst_n,
	input  wire        i2c_mode_t mode,
	input  wire        dev_addr_t dev_addr,
	input  wire        byte_t reg_addr,
	input  wire        byte_t wr_data,
	input  wire        count_t byte_count,
	input  wire        phase_done,
	input  wire        ack_bit,
	output phase_cmd_t cmd,
	output logic       ev_phase_end,
	output logic       ev_byte_read,
	output logic       ev_xfer_end,
	output phase_t     ev_phase,
	output logic       ev_ack
);

	typedef enum logic [3:0] {
		st_idle,
		st_start,
		st_dev_w,
		st_dev_w_ack,
		st_reg,
		st_reg_ack,
		st_wr,
		st_wr_ack,
		st_restart,
		st_dev_r,
		st_dev_r_ack,
		st_rd,
		st_rd_ack,
		st_stop
	} seq_state_t;

	seq_state_t state;
	seq_state_t state_nx;
	phase_cmd_t cmd_nx;

	logic   launch;
	logic   rd_q;     // read mode latched at launch
	count_t last_q;   // index of the final data byte
	count_t byte_cnt;
	logic   is_last;

	assign launch  = (state == st_idle) && (mode != wait_bus);
	assign is_last = (byte_cnt == last_q);

	always_comb begin
		state_nx = state;
		cmd_nx   = cmd;
		if (launch) begin
			state_nx = st_start;
			cmd_nx   = '{ph_start, 8'h00};
		end else if (phase_done) begin
			case (state)
				st_start: begin
					state_nx = st_dev_w;
					cmd_nx   = '{ph_tx_byte, {dev_addr, 1'b0}}; // address + write
				end
				st_dev_w: begin
					state_nx = st_dev_w_ack;
					cmd_nx   = '{ph_rx_ack, 8'h00};
				end
				st_dev_w_ack: begin
					if (ack_bit) begin
						state_nx = st_stop;
						cmd_nx   = '{ph_stop, 8'h00};
					end else begin
						state_nx = st_reg;
						cmd_nx   = '{ph_tx_byte, reg_addr};
					end
				end
				st_reg: begin
					state_nx = st_reg_ack;
					cmd_nx   = '{ph_rx_ack, 8'h00};
				end
				st_reg_ack: begin
					if (ack_bit) begin
						state_nx = st_stop;
						cmd_nx   = '{ph_stop, 8'h00};
					end else if (rd_q) begin
						state_nx = st_restart;
						cmd_nx   = '{ph_restart, 8'h00};
					end else begin
						state_nx = st_wr;
						cmd_nx   = '{ph_tx_byte, wr_data};
					end
				end
				st_wr: begin
					state_nx = st_wr_ack;
					cmd_nx   = '{ph_rx_ack, 8'h00};
				end
				st_wr_ack: begin
					if (ack_bit || is_last) begin
						state_nx = st_stop;
						cmd_nx   = '{ph_stop, 8'h00};
					end else begin
						state_nx = st_wr;
						cmd_nx   = '{ph_tx_byte, wr_data}; // next burst byte
					end
				end
				st_restart: begin
					state_nx = st_dev_r;
					cmd_nx   = '{ph_tx_byte, {dev_addr, 1'b1}}; // address + read
				end
				st_dev_r: begin
					state_nx = st_dev_r_ack;
					cmd_nx   = '{ph_rx_ack, 8'h00};
				end
				st_dev_r_ack: begin
					if (ack_bit) begin
						state_nx = st_stop;
						cmd_nx   = '{ph_stop, 8'h00};
					end else begin
						state_nx = st_rd;
						cmd_nx   = '{ph_rx_byte, 8'h00};
					end
				end
				st_rd: begin
					state_nx = st_rd_ack;
					cmd_nx   = is_last ? '{ph_tx_nack, 8'h00} : '{ph_tx_ack, 8'h00};
				end
				st_rd_ack: begin
					if (cmd.phase == ph_tx_nack) begin
						state_nx = st_stop;
						cmd_nx   = '{ph_stop, 8'h00};
					end else begin
						state_nx = st_rd;
						cmd_nx   = '{ph_rx_byte, 8'h00};
					end
				end
				st_stop: begin
					state_nx = st_idle;
					cmd_nx   = '{ph_idle, 8'h00};
				end
				default: begin
					state_nx = st_idle;
					cmd_nx   = '{ph_idle, 8'h00};
				end
			endcase
		end
	end

	always_ff @(posedge clk_in or negedge rst_n) begin
		if (!rst_n) begin
			state    <= st_idle;
			cmd      <= '{ph_idle, 8'h00};
			rd_q     <= 1'b0;
			last_q   <= '0;
			byte_cnt <= '0;
		end else begin
			state <= state_nx;
			cmd   <= cmd_nx;
			if (launch) begin
				rd_q     <= (mode == read_single) || (mode == read_burst);
				byte_cnt <= '0;
				if ((mode == write_burst || mode == read_burst) && byte_count != '0)
					last_q <= byte_count - 8'd1;
				else
					last_q <= '0; // single modes move one byte
			end else if (phase_done && (state == st_wr_ack || state == st_rd_ack)) begin
				byte_cnt <= byte_cnt + 8'd1;
			end
		end
	end

	assign ev_phase_end = phase_done;
	assign ev_byte_read = phase_done && (state == st_rd);
	assign ev_xfer_end  = phase_done && (state == st_stop);
	assign ev_phase     = cmd.phase;
	assign ev_ack       = ack_bit;

endmodule

`default_nettype wire

// ==== logic/i2c_status.sv ====
`default_nettype none

module i2c_status import i2c_pkg::*; (
	input  wire        clk_in,
	input  wire        rst_n,
	input  wire        ev_phase_end,
	input  wire        ev_byte_read,
	input  wire        ev_xfer_end,
	input  wire        phase_t ev_phase,
	input  wire        ev_ack,
	input  wire        byte_t rx_byte,
	output byte_t      rd_data,
	output logic       rd_valid,
	output ack_flags_t ack_status,
	output logic       xfer_done
);

	logic       restarted; // read address phase follows the restart
	logic [1:0] ack_idx;   // slave acks seen before any restart

	always_ff @(posedge clk_in or negedge rst_n) begin
		if (!rst_n) begin
			ack_status <= '0;
			rd_valid   <= 1'b0;
			restarted  <= 1'b0;
			ack_idx    <= '0;
		end else begin
			ack_status <= '0;
			rd_valid   <= ev_byte_read;
			if (ev_phase_end) begin
				case (ev_phase)
					ph_rx_ack: begin
						if (ev_ack)
							ack_status.nack <= 1'b1;
						else if (restarted)
							ack_status.rd_dev_ack <= 1'b1;
						else if (ack_idx == 2'd0)
							ack_status.dev_ack <= 1'b1;
						else if (ack_idx == 2'd1)
							ack_status.reg_ack <= 1'b1;
						else
							ack_status.wr_ack <= 1'b1;
						if (ack_idx != 2'd2)
							ack_idx <= ack_idx + 2'd1;
					end
					ph_restart: restarted <= 1'b1;
					ph_tx_ack:  ack_status.master_ack <= 1'b1;
					ph_tx_nack: ack_status.master_nack <= 1'b1;
					default: ;
				endcase
			end
			if (ev_xfer_end) begin
				restarted <= 1'b0;
				ack_idx   <= '0;
			end
		end
	end

	always_ff @(posedge clk_in) begin
		if (ev_byte_read)
			rd_data <= rx_byte;
	end

	assign xfer_done = ev_xfer_end; // last stop cycle

endmodule

`default_nettype wire

// ==== verification/i2c_slave_model.sv ====
`default_nettype none

module i2c_slave_model #(
	parameter logic [6:0] SLAVE_ADDR = 7'h52
) (
	input wire clk_in, // bus sampled on its falling edge
	input wire scl,
	inout wire sda
);
	timeunit 1ns;
	timeprecision 100ps;

	logic [7:0] mem [0:255];
	logic [7:0] ptr;      // auto-increments per data byte
	logic [7:0] shreg;
	int         cnt;      // scl rises in this 9-bit frame
	int         kind;     // 0 device address, 1 register, 2 data
	logic       active;
	logic       sending;
	logic       want_read;
	logic       refused;
	logic       got_ack;
	logic       drive_low;
	logic       scl_q;
	logic       sda_q;
	logic       sda_s;

	assign sda = drive_low ? 1'b0 : 1'bz;

	initial begin
		for (int i = 0; i < 256; i++)
			mem[i] = 8'h00;
		ptr       = 8'h00;
		cnt       = 0;
		kind      = 0;
		active    = 1'b0;
		sending   = 1'b0;
		want_read = 1'b0;
		refused   = 1'b0;
		got_ack   = 1'b0;
		drive_low = 1'b0;
		scl_q     = 1'b1;
		sda_q     = 1'b1;
	end

	// incoming byte complete, answer in the ack slot
	task automatic take_byte();
		refused = 1'b0;
		if (kind == 0) begin
			refused   = (shreg[7:1] != SLAVE_ADDR);
			want_read = shreg[0];
		end else if (kind == 1) begin
			ptr = shreg;
		end else begin
			mem[ptr] = shreg;
			ptr      = ptr + 8'd1;
		end
		drive_low = !refused;
	endtask

	task automatic scl_fall();
		if (cnt == 9) begin
			cnt       = 0;
			drive_low = 1'b0;
			if (refused || (sending && !got_ack)) begin
				active = 1'b0; // idle until the stop
			end else if (sending || want_read) begin
				sending   = 1'b1;
				shreg     = mem[ptr];
				ptr       = ptr + 8'd1;
				drive_low = !shreg[7];
			end else if (kind < 2) begin
				kind++;
			end
		end else if (cnt == 8) begin
			if (sending)
				drive_low = 1'b0; // master's ack slot
			else
				take_byte();
		end else if (sending && cnt > 0) begin
			drive_low = !shreg[7 - cnt];
		end
	endtask

	always @(negedge clk_in) begin
		sda_s = (sda !== 1'b0);
		if (scl && scl_q && sda_q && !sda_s) begin
			// start or repeated start
			active    = 1'b1;
			sending   = 1'b0;
			refused   = 1'b0;
			kind      = 0;
			cnt       = 0;
			drive_low = 1'b0;
		end else if (scl && scl_q && !sda_q && sda_s) begin
			active    = 1'b0; // stop
			drive_low = 1'b0;
		end else if (active && scl && !scl_q) begin
			if (!sending && cnt < 8)
				shreg = {shreg[6:0], sda_s};
			if (sending && cnt == 8)
				got_ack = !sda_s;
			cnt++;
		end else if (active && !scl && scl_q) begin
			scl_fall();
		end
		scl_q = scl;
		sda_q = sda_s;
	end

endmodule

`default_nettype wire

// ==== verification/tb_i2c_master.sv ====
`default_nettype none

module tb_i2c_master import i2c_pkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam dev_addr_t SLAVE_ADDR = 7'h52;

	logic       clk_in;
	logic       rst_n;
	i2c_mode_t  mode;
	dev_addr_t  dev_addr;
	byte_t      reg_addr;
	byte_t      wr_data;
	count_t     byte_count;
	wire        scl;
	wire        sda;
	byte_t      rd_data;
	logic       rd_valid;
	ack_flags_t ack_status;
	logic       xfer_done;

	integer seed;
	byte_t  ref_mem [0:255]; // expected slave memory
	byte_t  wr_buf [0:7];
	byte_t  rd_q [$];
	int     flag_cnt [0:6];
	int     xfer_cnt;
	int     errors;
	int     tests_run;
	int     tests_bad;
	string  flag_name [0:6] = '{"dev_ack", "reg_ack", "wr_ack", "rd_dev_ack",
		"master_ack", "master_nack", "nack"};

	pullup (sda);

	i2c_master #(.STOP_CYCLES(6)) dut0 (
		.clk_in     (clk_in),
		.rst_n      (rst_n),
		.mode       (mode),
		.dev_addr   (dev_addr),
		.reg_addr   (reg_addr),
		.wr_data    (wr_data),
		.byte_count (byte_count),
		.scl        (scl),
		.sda        (sda),
		.rd_data    (rd_data),
		.rd_valid   (rd_valid),
		.ack_status (ack_status),
		.xfer_done  (xfer_done)
	);

	i2c_slave_model #(.SLAVE_ADDR(SLAVE_ADDR)) slave0 (
		.clk_in (clk_in),
		.scl    (scl),
		.sda    (sda)
	);

	always #4 clk_in = ~clk_in;

	// pulses counted mid-cycle
	always @(negedge clk_in) begin
		if (rst_n) begin
			flag_cnt[0] += ack_status.dev_ack;
			flag_cnt[1] += ack_status.reg_ack;
			flag_cnt[2] += ack_status.wr_ack;
			flag_cnt[3] += ack_status.rd_dev_ack;
			flag_cnt[4] += ack_status.master_ack;
			flag_cnt[5] += ack_status.master_nack;
			flag_cnt[6] += ack_status.nack;
			xfer_cnt    += xfer_done;
			if (rd_valid)
				rd_q.push_back(rd_data);
		end
	end

	task automatic check_value(input string name, input int got, input int exp);
		if (got != exp) begin
			$display("error at time %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_flags(input int e0, e1, e2, e3, e4, e5, e6);
		int exp [0:6];
		exp = '{e0, e1, e2, e3, e4, e5, e6};
		for (int i = 0; i < 7; i++)
			check_value({"ack_status.", flag_name[i], " pulses"}, flag_cnt[i], exp[i]);
	endtask

	task automatic check_reads(input byte_t r, input int n);
		check_value("rd_valid pulses", rd_q.size(), n);
		for (int k = 0; k < n && k < rd_q.size(); k++)
			check_value($sformatf("rd_data byte %0d", k), rd_q[k], ref_mem[byte_t'(r + k)]);
	endtask

	task automatic compare_memory();
		for (int a = 0; a < 256; a++)
			check_value($sformatf("slave0.mem[%0h]", a), slave0.mem[a], ref_mem[a]);
	endtask

	task automatic report_test(input string name, input int errs_before);
		tests_run++;
		if (errors == errs_before) begin
			$display("%s: ok", name);
		end else begin
			tests_bad++;
			$display("%s: %0d errors", name, errors - errs_before);
		end
	endtask

	// wr_data moves to the next byte once the current one has been taken
	task automatic run_xfer(input i2c_mode_t m, input dev_addr_t dev, input byte_t r,
			input count_t n);
		int idx;
		bit done;
		bit next;
		idx  = 0;
		done = 1'b0;
		for (int i = 0; i < 7; i++)
			flag_cnt[i] = 0;
		xfer_cnt = 0;
		rd_q.delete();
		@(posedge clk_in);
		mode       <= m;
		dev_addr   <= dev;
		reg_addr   <= r;
		wr_data    <= wr_buf[0];
		byte_count <= n;
		for (int cyc = 0; cyc < 1000 && !done; cyc++) begin
			@(negedge clk_in);
			done = xfer_done;
			next = ack_status.reg_ack || ack_status.wr_ack;
			@(posedge clk_in);
			if (done) begin
				mode <= wait_bus;
			end else if (next && idx < 7) begin
				idx++;
				wr_data <= wr_buf[idx];
			end
		end
		if (!done) begin
			$display("timeout: xfer_done did not arrive within 1000 cycles");
			errors++;
			mode <= wait_bus;
		end
	endtask

	initial begin
		int        e;
		int        n;
		byte_t     r;
		dev_addr_t bad;
		seed       = 32'h71e0_54f9;
		clk_in     = 1'b0;
		rst_n      = 1'b0;
		mode       = wait_bus;
		dev_addr   = '0;
		reg_addr   = '0;
		wr_data    = '0;
		byte_count = '0;
		errors     = 0;
		tests_run  = 0;
		tests_bad  = 0;
		for (int a = 0; a < 256; a++)
			ref_mem[a] = 8'h00;
		repeat (5) @(posedge clk_in);
		rst_n <= 1'b1;

		e = errors;
		repeat (50) begin
			@(negedge clk_in);
			check_value("scl", scl, 1);
			check_value("sda", sda, 1);
		end
		check_value("xfer_done pulses", xfer_cnt, 0);
		check_value("rd_valid pulses", rd_q.size(), 0);
		check_flags(0, 0, 0, 0, 0, 0, 0);
		report_test("idle bus", e);

		for (int round = 0; round < 3; round++) begin
			e = errors;
			r = byte_t'($random(seed));
			wr_buf[0] = byte_t'($random(seed));
			run_xfer(write_single, SLAVE_ADDR, r, 8'd1);
			ref_mem[r] = wr_buf[0];
			check_flags(1, 1, 1, 0, 0, 0, 0);
			run_xfer(read_single, SLAVE_ADDR, r, 8'd1);
			check_flags(1, 1, 0, 1, 0, 1, 0);
			check_reads(r, 1);
			report_test("single write, single read", e);

			e = errors;
			n = ($random(seed) & 7) + 1;
			for (int k = 0; k < n; k++)
				wr_buf[k] = byte_t'($random(seed));
			run_xfer(write_burst, SLAVE_ADDR, r, count_t'(n));
			for (int k = 0; k < n; k++)
				ref_mem[byte_t'(r + k)] = wr_buf[k];
			check_flags(1, 1, n, 0, 0, 0, 0);
			compare_memory();
			report_test($sformatf("burst write of %0d", n), e);

			e = errors;
			n = ($random(seed) & 7) + 1;
			run_xfer(read_burst, SLAVE_ADDR, r, count_t'(n));
			check_flags(1, 1, 0, 1, n - 1, 1, 0);
			check_reads(r, n);
			report_test($sformatf("burst read of %0d", n), e);
		end

		e = errors;
		bad = SLAVE_ADDR + dev_addr_t'({$random(seed)} % 127 + 1); // never the slave's
		wr_buf[0] = byte_t'($random(seed));
		run_xfer(write_single, bad, byte_t'($random(seed)), 8'd1);
		check_flags(0, 0, 0, 0, 0, 0, 1);
		check_value("xfer_done pulses", xfer_cnt, 1);
		compare_memory();
		report_test("wrong device address", e);

		$display("%0d tests, %0d failed, %0d errors", tests_run, tests_bad, errors);
		if (errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
